/* all.f */
design/ex_arch_pkg.sv
design/ex_op_pkg.sv
design/ex_issue_reg.sv
design/ex_alu.sv
design/ex_mult_seq.sv
design/ex_result_stage.sv
design/ex_stage_top.sv
sim/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the execute-stage testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_ex_stage \
  -f all.f \
  -o tb_ex_stage

./obj_dir/tb_ex_stage

/* sim/tb_ex_stage.sv */
// Directed testbench for the execute stage: ALU, branch and multiply paths.
// Inputs change on the falling edge and outputs are sampled there too.

module tb_ex_stage;

  import ex_arch_pkg::*;
  import ex_op_pkg::*;

  localparam int unsigned TimeoutCycles = 600;       // about twice the test length
  localparam int unsigned MulLatency    = XLEN + 2;  // edges from issue edge to valid

  logic        clk_i;
  logic        rst_ni;
  logic        issue_valid_i;
  exec_unit_e  issue_unit_i;
  alu_op_e     alu_op_i;
  word_t       operand_a_i;
  word_t       operand_b_i;
  word_t       bt_a_i;
  word_t       bt_b_i;
  reg_addr_t   rf_waddr_i;
  logic        rf_we_i;
  logic        busy_o;
  logic        result_valid_o;
  word_t       result_o;
  reg_addr_t   rf_waddr_o;
  logic        rf_we_o;
  logic        branch_decision_o;
  word_t       branch_target_o;
  int unsigned cycle_cnt = 0;
  int unsigned seed_ret;

  ex_stage_top #(.BranchTargetAlu(1'b1)) ex_stage_top_inst (
    .clk_i, .rst_ni, .issue_valid_i, .issue_unit_i, .alu_op_i,
    .operand_a_i, .operand_b_i, .bt_a_i, .bt_b_i, .rf_waddr_i, .rf_we_i,
    .busy_o, .result_valid_o, .result_o, .rf_waddr_o, .rf_we_o,
    .branch_decision_o, .branch_target_o
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run("simulation ran past the cycle limit without finishing");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // signed compare done as unsigned on offset-binary values
  function automatic bit model_lt_signed(word_t a, word_t b);
    return {~a[XLEN-1], a[XLEN-2:0]} < {~b[XLEN-1], b[XLEN-2:0]};
  endfunction

  function automatic bit model_compare(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return model_lt_signed(a, b);
      ALU_GE:            return !model_lt_signed(a, b);
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic bit model_branch(alu_op_e op, word_t a, word_t b);
    if (op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU}) begin
      return model_compare(op, a, b);
    end
    return 1'b0;
  endfunction

  function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
    int unsigned sh;
    word_t       fill;
    sh   = b[4:0];
    fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;  // sign bits shifted in by sra
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a + ~b + word_t'(1);
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return (a >> sh) | fill;
      default: return word_t'(model_compare(op, a, b));
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("Fail: time %0t, %s expected %h, actual %h", $time, name, exp, act);
      abort_run("word mismatch");
    end
  endtask

  task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
    if (act !== exp) begin
      $display("Fail: time %0t, %s expected %0d, actual %0d", $time, name, exp, act);
      abort_run("register address mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail: time %0t, %s expected %b, actual %b", $time, name, exp, act);
      abort_run("flag mismatch");
    end
  endtask

  task automatic check_latency(string name, int unsigned exp, int unsigned act);
    if (act != exp) begin
      $display("Fail: time %0t, %s expected %0d edges, actual %0d", $time, name, exp, act);
      abort_run("latency mismatch");
    end
  endtask

  task automatic drive_idle();
    issue_valid_i = 1'b0;
    issue_unit_i  = UNIT_ALU;
    alu_op_i      = ALU_ADD;
    operand_a_i   = '0;
    operand_b_i   = '0;
    bt_a_i        = '0;
    bt_b_i        = '0;
    rf_waddr_i    = '0;
    rf_we_i       = 1'b0;
  endtask

  task automatic drive_issue(exec_unit_e unit, alu_op_e op, word_t a, word_t b,
                             word_t bta, word_t btb, reg_addr_t wa, logic we);
    issue_valid_i = 1'b1;
    issue_unit_i  = unit;
    alu_op_i      = op;
    operand_a_i   = a;
    operand_b_i   = b;
    bt_a_i        = bta;
    bt_b_i        = btb;
    rf_waddr_i    = wa;
    rf_we_i       = we;
  endtask

  task automatic check_alu_out(alu_op_e op, word_t a, word_t b, word_t bta, word_t btb,
                               reg_addr_t wa, logic we);
    check_bit("result_valid_o", 1'b1, result_valid_o);
    check_word("result_o", model_alu(op, a, b), result_o);
    check_addr("rf_waddr_o", wa, rf_waddr_o);
    check_bit("rf_we_o", we, rf_we_o);
    check_bit("branch_decision_o", model_branch(op, a, b), branch_decision_o);
    check_word("branch_target_o", bta + btb, branch_target_o);
  endtask

  // starts on a falling edge and ends on one, three cycles per operation
  task automatic run_alu_op(alu_op_e op, word_t a, word_t b);
    word_t     bta;
    word_t     btb;
    reg_addr_t wa;
    logic      we;
    bta = $urandom();
    btb = $urandom();
    wa  = reg_addr_t'($urandom_range(31, 1));
    we  = ($urandom_range(1, 0) == 1);
    drive_issue(UNIT_ALU, op, a, b, bta, btb, wa, we);
    @(negedge clk_i);
    drive_idle();
    check_bit("result_valid_o", 1'b0, result_valid_o);
    @(negedge clk_i);
    check_alu_out(op, a, b, bta, btb, wa, we);
    @(negedge clk_i);
    check_bit("result_valid_o", 1'b0, result_valid_o);  // one-cycle pulse
  endtask

  task automatic run_mul(word_t a, word_t b, bit issue_while_busy);
    reg_addr_t   wa;
    int unsigned edges;
    wa = reg_addr_t'($urandom_range(31, 1));
    drive_issue(UNIT_MUL, ALU_ADD, a, b, $urandom(), $urandom(), wa, 1'b1);
    @(negedge clk_i);  // issue edge has passed
    drive_idle();
    edges = 0;
    while (!result_valid_o) begin
      check_bit("busy_o", 1'b1, busy_o);
      if (edges > MulLatency + 4) begin
        abort_run("multiply result never became valid");
      end
      @(negedge clk_i);
      edges++;
      if (issue_while_busy && edges == 2) begin
        drive_issue(UNIT_ALU, ALU_OR, $urandom(), $urandom(), '0, '0, wa, 1'b1);
      end else begin
        drive_idle();
      end
    end
    check_latency("result_valid_o", MulLatency, edges);
    check_bit("busy_o", 1'b1, busy_o);
    check_word("result_o", a * b, result_o);   // low product word
    check_addr("rf_waddr_o", wa, rf_waddr_o);
    check_bit("rf_we_o", 1'b1, rf_we_o);
    check_bit("branch_decision_o", 1'b0, branch_decision_o);
    check_word("branch_target_o", '0, branch_target_o);
    @(negedge clk_i);
    check_bit("result_valid_o", 1'b0, result_valid_o);
    check_bit("busy_o", 1'b0, busy_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    rst_ni = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("result_valid_o", 1'b0, result_valid_o);
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("rf_we_o", 1'b0, rf_we_o);
    check_bit("branch_decision_o", 1'b0, branch_decision_o);
    check_word("result_o", '0, result_o);
    check_addr("rf_waddr_o", '0, rf_waddr_o);
    check_word("branch_target_o", '0, branch_target_o);
    @(negedge clk_i);
    check_bit("result_valid_o", 1'b0, result_valid_o);
  endtask

  // back-to-back issues, two in flight at a time
  task automatic test_arith_logic();
    alu_op_e   ops [5];
    word_t     a_v [5];
    word_t     b_v [5];
    word_t     bta_v [5];
    word_t     btb_v [5];
    reg_addr_t wa_v [5];
    logic      we_v [5];
    ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    for (int i = 0; i < 5; i++) begin
      a_v[i]   = $urandom();
      b_v[i]   = $urandom();
      bta_v[i] = $urandom();
      btb_v[i] = $urandom();
      wa_v[i]  = reg_addr_t'(i + 3);
      we_v[i]  = (i != 2);
    end
    for (int i = 0; i < 7; i++) begin
      if (i >= 2) begin
        check_alu_out(ops[i-2], a_v[i-2], b_v[i-2], bta_v[i-2], btb_v[i-2],
                      wa_v[i-2], we_v[i-2]);
      end else begin
        check_bit("result_valid_o", 1'b0, result_valid_o);
      end
      if (i < 5) begin
        drive_issue(UNIT_ALU, ops[i], a_v[i], b_v[i], bta_v[i], btb_v[i], wa_v[i], we_v[i]);
      end else begin
        drive_idle();
      end
      @(negedge clk_i);
    end
    check_bit("result_valid_o", 1'b0, result_valid_o);
  endtask

  task automatic test_shift_slt();
    alu_op_e ops [5];
    word_t   a_v [2];
    word_t   b_v [3];
    ops = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    a_v = '{32'h8765_4321, 32'h7fff_fffe};
    b_v = '{32'h0000_0000, 32'h0000_001f, 32'h8000_0004};  // shamt 0, 31, 4
    foreach (ops[i]) begin
      foreach (a_v[j]) begin
        foreach (b_v[k]) begin
          run_alu_op(ops[i], a_v[j], b_v[k]);
        end
      end
    end
  endtask

  task automatic test_branches();
    alu_op_e ops [6];
    word_t   a_v [4];
    word_t   b_v [4];
    ops    = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    a_v[0] = $urandom();
    b_v[0] = a_v[0];                                        // equal
    a_v[1] = 32'h0000_0005;
    b_v[1] = 32'h0000_0009;                                 // lower
    a_v[2] = 32'h8000_0000;
    b_v[2] = 32'h0000_0001;  // lower signed, higher unsigned
    a_v[3] = 32'h0000_0001;
    b_v[3] = 32'h8000_0000;
    foreach (ops[i]) begin
      foreach (a_v[j]) begin
        run_alu_op(ops[i], a_v[j], b_v[j]);
      end
    end
  endtask

  task automatic test_multiply();
    run_mul($urandom(), $urandom(), 1'b0);
    run_mul(32'h0000_0000, $urandom(), 1'b0);
    run_mul(32'hffff_ffff, 32'hffff_ffff, 1'b1);  // ALU issue dropped while busy
    run_mul($urandom(), 32'hffff_ffff, 1'b0);
  endtask

  initial begin
    seed_ret = $urandom(32'hec69);
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    drive_idle();
    test_reset();
    test_arith_logic();
    test_shift_slt();
    test_branches();
    test_multiply();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* design/ex_stage_top.sv */
// Execute stage of the RV32 core: ID/EX register, ALU, sequential
// multiplier and the EX/MA result register.

module ex_stage_top #(
  parameter bit BranchTargetAlu = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   issue_valid_i,
  input  ex_op_pkg::exec_unit_e  issue_unit_i,
  input  ex_op_pkg::alu_op_e     alu_op_i,
  input  ex_arch_pkg::word_t     operand_a_i,
  input  ex_arch_pkg::word_t     operand_b_i,
  input  ex_arch_pkg::word_t     bt_a_i,
  input  ex_arch_pkg::word_t     bt_b_i,
  input  ex_arch_pkg::reg_addr_t rf_waddr_i,
  input  logic                   rf_we_i,

  output logic                   busy_o,          // decoder must not issue
  output logic                   result_valid_o,
  output ex_arch_pkg::word_t     result_o,
  output ex_arch_pkg::reg_addr_t rf_waddr_o,
  output logic                   rf_we_o,
  output logic                   branch_decision_o,
  output ex_arch_pkg::word_t     branch_target_o
);

  import ex_arch_pkg::*;
  import ex_op_pkg::*;

  logic      alu_valid, mul_start;
  alu_op_e   ex_alu_op;
  word_t     ex_op_a, ex_op_b, ex_bt_a, ex_bt_b;
  reg_addr_t ex_rf_waddr;
  logic      ex_rf_we;

  word_t     alu_result, alu_branch_target;
  logic      alu_branch_decision;

  logic      mul_done;
  word_t     mul_product;
  reg_addr_t mul_rf_waddr;
  logic      mul_rf_we;

  ex_issue_reg ex_issue_reg_inst (
    .clk_i, .rst_ni, .issue_valid_i, .issue_unit_i, .alu_op_i,
    .operand_a_i, .operand_b_i, .bt_a_i, .bt_b_i, .rf_waddr_i, .rf_we_i,
    .mul_busy_i  (busy_o),
    .alu_valid_o (alu_valid),
    .mul_start_o (mul_start),
    .alu_op_o    (ex_alu_op),
    .operand_a_o (ex_op_a),
    .operand_b_o (ex_op_b),
    .bt_a_o      (ex_bt_a),
    .bt_b_o      (ex_bt_b),
    .rf_waddr_o  (ex_rf_waddr),
    .rf_we_o     (ex_rf_we)
  );

  ex_alu #(.BranchTargetAlu(BranchTargetAlu)) ex_alu_inst (
    .alu_op_i (ex_alu_op), .operand_a_i (ex_op_a), .operand_b_i (ex_op_b),
    .bt_a_i (ex_bt_a), .bt_b_i (ex_bt_b), .result_o (alu_result),
    .branch_decision_o (alu_branch_decision), .branch_target_o (alu_branch_target)
  );

  ex_mult_seq ex_mult_seq_inst (
    .clk_i, .rst_ni, .start_i (mul_start),
    .operand_a_i (ex_op_a), .operand_b_i (ex_op_b),
    .rf_waddr_i (ex_rf_waddr), .rf_we_i (ex_rf_we),
    .busy_o, .done_o (mul_done), .product_o (mul_product),
    .rf_waddr_o (mul_rf_waddr), .rf_we_o (mul_rf_we)
  );

  ex_result_stage ex_result_stage_inst (
    .clk_i, .rst_ni,
    .alu_valid_i (alu_valid), .alu_result_i (alu_result),
    .alu_branch_decision_i (alu_branch_decision), .alu_branch_target_i (alu_branch_target),
    .alu_rf_waddr_i (ex_rf_waddr), .alu_rf_we_i (ex_rf_we),
    .mul_done_i (mul_done), .mul_product_i (mul_product),
    .mul_rf_waddr_i (mul_rf_waddr), .mul_rf_we_i (mul_rf_we),
    .result_valid_o, .result_o, .rf_waddr_o, .rf_we_o,
    .branch_decision_o, .branch_target_o
  );

endmodule

/* design/ex_result_stage.sv */
// EX/MA register. Takes the result of whichever unit finished this cycle.
// Idle cycles clear the valid, write enable and branch flags only.

module ex_result_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // ALU side
  input  logic                   alu_valid_i,
  input  ex_arch_pkg::word_t     alu_result_i,
  input  logic                   alu_branch_decision_i,
  input  ex_arch_pkg::word_t     alu_branch_target_i,
  input  ex_arch_pkg::reg_addr_t alu_rf_waddr_i,
  input  logic                   alu_rf_we_i,

  // multiplier side
  input  logic                   mul_done_i,
  input  ex_arch_pkg::word_t     mul_product_i,
  input  ex_arch_pkg::reg_addr_t mul_rf_waddr_i,
  input  logic                   mul_rf_we_i,

  // to memory access
  output logic                   result_valid_o,
  output ex_arch_pkg::word_t     result_o,
  output ex_arch_pkg::reg_addr_t rf_waddr_o,
  output logic                   rf_we_o,
  output logic                   branch_decision_o,
  output ex_arch_pkg::word_t     branch_target_o
);

  ////////////////////////////////////////////////////////////////////////////
  // EX/MA register
  ////////////////////////////////////////////////////////////////////////////

  // busy gating upstream keeps the two strobes apart
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o    <= 1'b0;
      result_o          <= '0;
      rf_waddr_o        <= '0;
      rf_we_o           <= 1'b0;
      branch_decision_o <= 1'b0;
      branch_target_o   <= '0;
    end else if (alu_valid_i) begin
      result_valid_o    <= 1'b1;
      result_o          <= alu_result_i;
      rf_waddr_o        <= alu_rf_waddr_i;
      rf_we_o           <= alu_rf_we_i;
      branch_decision_o <= alu_branch_decision_i;
      branch_target_o   <= alu_branch_target_i;
    end else if (mul_done_i) begin
      result_valid_o    <= 1'b1;
      result_o          <= mul_product_i;
      rf_waddr_o        <= mul_rf_waddr_i;
      rf_we_o           <= mul_rf_we_i;
      branch_decision_o <= 1'b0;  // a multiply never branches
      branch_target_o   <= '0;
    end else begin
      // bubble, data outputs keep their last value
      result_valid_o    <= 1'b0;
      rf_we_o           <= 1'b0;
      branch_decision_o <= 1'b0;
    end
  end

endmodule

/* design/ex_mult_seq.sv */
// Iterative shift-add multiplier, low XLEN bits of an unsigned product.
// Loads on start_i, runs XLEN steps, then presents the product for one cycle.

module ex_mult_seq (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   start_i,
  input  ex_arch_pkg::word_t     operand_a_i,
  input  ex_arch_pkg::word_t     operand_b_i,
  input  ex_arch_pkg::reg_addr_t rf_waddr_i,
  input  logic                   rf_we_i,

  output logic                   busy_o,
  output logic                   done_o,
  output ex_arch_pkg::word_t     product_o,
  output ex_arch_pkg::reg_addr_t rf_waddr_o,
  output logic                   rf_we_o
);

  import ex_arch_pkg::*;
  import ex_op_pkg::*;

  localparam int unsigned CntW = $clog2(XLEN);

  mult_state_e     state_q, state_d;
  logic [CntW-1:0] cnt_q;
  word_t           mcand_q;    // shifts left each step
  word_t           mplier_q;   // shifts right, low bit picks the add
  word_t           acc_q;
  logic            drain_q;    // result stage holds the product this cycle
  logic            last_step;

  assign last_step = (cnt_q == CntW'(XLEN - 1));

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MUL_IDLE: if (start_i) state_d = MUL_ITER;
      MUL_ITER: if (last_step) state_d = MUL_DONE;
      MUL_DONE: state_d = MUL_IDLE;  // one-cycle done strobe
      default:  state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MUL_IDLE;
      drain_q <= 1'b0;
    end else begin
      state_q <= state_d;
      drain_q <= (state_q == MUL_DONE);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      mcand_q    <= '0;
      mplier_q   <= '0;
      acc_q      <= '0;
      rf_waddr_o <= '0;
      rf_we_o    <= 1'b0;
    end else if (state_q == MUL_IDLE && start_i) begin
      cnt_q      <= '0;
      mcand_q    <= operand_a_i;
      mplier_q   <= operand_b_i;
      acc_q      <= '0;
      rf_waddr_o <= rf_waddr_i;  // metadata rides along with the operation
      rf_we_o    <= rf_we_i;
    end else if (state_q == MUL_ITER) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
      cnt_q    <= cnt_q + 1'b1;
    end
  end

  assign done_o    = (state_q == MUL_DONE);
  assign product_o = acc_q;

  // pending start in ID/EX counts as busy too, so a second issue is dropped
  assign busy_o = start_i | (state_q != MUL_IDLE) | drain_q;

endmodule

/* design/ex_alu.sv */
// Combinational integer ALU with branch comparison and branch target.
// BranchTargetAlu selects a dedicated target adder or reuse of a + b.

module ex_alu #(
  parameter bit BranchTargetAlu = 1'b0
) (
  input  ex_op_pkg::alu_op_e alu_op_i,
  input  ex_arch_pkg::word_t operand_a_i,
  input  ex_arch_pkg::word_t operand_b_i,
  input  ex_arch_pkg::word_t bt_a_i,   // only read with the target adder
  input  ex_arch_pkg::word_t bt_b_i,

  output ex_arch_pkg::word_t result_o,
  output logic               branch_decision_o,
  output ex_arch_pkg::word_t branch_target_o
);

  import ex_arch_pkg::*;
  import ex_op_pkg::*;

  word_t      add_res;
  word_t      sub_res;
  logic [4:0] shamt;
  logic       is_eq;
  logic       is_lt;    // signed
  logic       is_ltu;   // unsigned
  logic       cmp_res;
  logic       is_cmp;

  ////////////////////////////////////////////////////////////////////////////
  // shared arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign add_res = operand_a_i + operand_b_i;
  assign sub_res = operand_a_i - operand_b_i;
  assign shamt   = operand_b_i[4:0];

  assign is_eq  = (operand_a_i == operand_b_i);
  assign is_lt  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_ltu = (operand_a_i < operand_b_i);

  // comparison outcome, also used by SLT/SLTU
  always_comb begin
    is_cmp  = 1'b1;
    cmp_res = 1'b0;
    unique case (alu_op_i)
      ALU_EQ:   cmp_res = is_eq;
      ALU_NE:   cmp_res = ~is_eq;
      ALU_LT:   cmp_res = is_lt;
      ALU_GE:   cmp_res = ~is_lt;
      ALU_LTU:  cmp_res = is_ltu;
      ALU_GEU:  cmp_res = ~is_ltu;
      ALU_SLT: begin
        is_cmp  = 1'b0;  // sets a register, no branch
        cmp_res = is_lt;
      end
      ALU_SLTU: begin
        is_cmp  = 1'b0;
        cmp_res = is_ltu;
      end
      default:  is_cmp = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ALU_ADD: result_o = add_res;
      ALU_SUB: result_o = sub_res;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt);
      default: result_o = {{(XLEN-1){1'b0}}, cmp_res};  // slt and compares
    endcase
  end

  assign branch_decision_o = is_cmp & cmp_res;

  // branch target
  if (BranchTargetAlu) begin : g_bt_adder
    assign branch_target_o = bt_a_i + bt_b_i;  // separate adder, off the ALU path
  end else begin : g_bt_shared
    assign branch_target_o = add_res;
  end

endmodule

/* design/ex_issue_reg.sv */
// ID/EX register. Captures an issued operation and steers it to one unit.
// Issues that arrive while the multiplier is busy are dropped here.

module ex_issue_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // from decode
  input  logic                   issue_valid_i,
  input  ex_op_pkg::exec_unit_e  issue_unit_i,
  input  ex_op_pkg::alu_op_e     alu_op_i,
  input  ex_arch_pkg::word_t     operand_a_i,
  input  ex_arch_pkg::word_t     operand_b_i,
  input  ex_arch_pkg::word_t     bt_a_i,
  input  ex_arch_pkg::word_t     bt_b_i,
  input  ex_arch_pkg::reg_addr_t rf_waddr_i,
  input  logic                   rf_we_i,
  input  logic                   mul_busy_i,

  // to the execution units
  output logic                   alu_valid_o,
  output logic                   mul_start_o,
  output ex_op_pkg::alu_op_e     alu_op_o,
  output ex_arch_pkg::word_t     operand_a_o,
  output ex_arch_pkg::word_t     operand_b_o,
  output ex_arch_pkg::word_t     bt_a_o,
  output ex_arch_pkg::word_t     bt_b_o,
  output ex_arch_pkg::reg_addr_t rf_waddr_o,
  output logic                   rf_we_o
);

  import ex_op_pkg::*;

  logic       issue_accept;
  logic       valid_q;
  exec_unit_e unit_q;

  assign issue_accept = issue_valid_i & ~mul_busy_i;  // no back-pressure, just drop

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_accept;
    end
  end

  // fields only move on an accepted issue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_q      <= UNIT_ALU;
      alu_op_o    <= ALU_ADD;
      operand_a_o <= '0;
      operand_b_o <= '0;
      bt_a_o      <= '0;
      bt_b_o      <= '0;
      rf_waddr_o  <= '0;
      rf_we_o     <= 1'b0;
    end else if (issue_accept) begin
      unit_q      <= issue_unit_i;
      alu_op_o    <= alu_op_i;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      bt_a_o      <= bt_a_i;
      bt_b_o      <= bt_b_i;
      rf_waddr_o  <= rf_waddr_i;
      rf_we_o     <= rf_we_i;
    end
  end

  // exactly one unit sees each operation
  assign alu_valid_o = valid_q & (unit_q == UNIT_ALU);
  assign mul_start_o = valid_q & (unit_q == UNIT_MUL);

endmodule

/* design/ex_op_pkg.sv */
// Operation encodings and FSM states used inside the execute stage.
// Shared by the decoder-facing ports, the ALU and the multiplier.

package ex_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,   // shifts take b[4:0]
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // branch comparisons, these drive the branch decision
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // which unit executes the issued operation
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } exec_unit_e;

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_ITER = 2'd1,  // one shift-add step per cycle
    MUL_DONE = 2'd2   // product ready for the result stage
  } mult_state_e;

endpackage

/* design/ex_arch_pkg.sv */
// Architectural widths and word types for the RV32 execute stage.
// Import where operands, results or register addresses are handled.

package ex_arch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data path width
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned XLEN = 32;  // RV32 integer width

  // register-file address width, x0..x31
  parameter int unsigned RegAddrW = 5;

  ////////////////////////////////////////////////////////////////////////////
  // word types
  ////////////////////////////////////////////////////////////////////////////

  // one data word: operands, results and branch targets
  typedef logic [XLEN-1:0] word_t;

  typedef logic [RegAddrW-1:0] reg_addr_t;  // write-back destination

endpackage
